// File: src/boss_params.svh
// Boss geometry and tuning constants
`ifndef BOSS_PARAMS_SVH
`define BOSS_PARAMS_SVH

// screen
`define SCREEN_W        1024

// boss body, a solid rectangle
`define BOSS_MAX_HP     100
`define BOSS_HGT        128
`define BOSS_LNG        96
`define BOSS_Y          400   // fixed top row
`define BOSS_X_INIT     464   // roughly centred
`define BOSS_STEP       2     // pixels per frame tick

// damage per hit
`define DMG_PROJECTILE  1
`define DMG_MELEE       3

// hit-point bar, 4 pixels per hit point
`define HP_BAR_X        312
`define HP_BAR_Y        40
`define HP_BAR_H        16

// colours, 4 bits per channel
`define COLOR_HIGH      12'h0_E_2
`define COLOR_MID       12'hF_A_0
`define COLOR_LOW       12'hE_1_1
`define COLOR_BAR       12'hD_2_2

`define HP_MID          60
`define HP_LOW          25

`endif

// File: src/boss_pkg.sv
// Boss subsystem types
`default_nettype none

package boss_pkg;

    // screen coordinate in pixels
    typedef logic [11:0] coord_t;

    // hit points, up to 100
    typedef logic [6:0] hp_t;

    typedef logic [3:0] aggro_t;

    // 4:4:4 colour
    typedef logic [11:0] rgb_t;

    // 0 menu, 1 single player, 2 two-player, 3 paused
    typedef logic [1:0] mode_t;

    localparam mode_t MODE_SINGLE = 2'd1;
    localparam mode_t MODE_DUAL   = 2'd2;

    // one pixel of the video stream with its timing
    typedef struct packed {
        logic [10:0] vcount;
        logic [10:0] hcount;
        logic        vsync;
        logic        vblnk;
        logic        hsync;
        logic        hblnk;
        rgb_t        rgb;
    } vga_t;

    typedef enum logic [1:0] {
        FIGHT_IDLE,
        FIGHT_ON,
        FIGHT_DEFEATED
    } fight_state_t;

endpackage

`default_nettype wire

// File: src/boss_ctrl.sv
// Boss fight control FSM
`timescale 1ns/1ps
`default_nettype none

module boss_ctrl (
    input  logic            clk,
    input  logic            arst_n,
    input  boss_pkg::mode_t game_mode,
    input  logic            game_start,
    input  logic            player2_game_start,
    input  boss_pkg::hp_t   boss_hp,
    output logic            hp_load,
    output logic            fight_en,
    output logic            boss_alive
);

    boss_pkg::fight_state_t state;
    boss_pkg::fight_state_t state_nxt;
    logic start_req;
    logic play_mode;

    // remote start only counts in two-player mode
    assign start_req = game_start ||
                       (player2_game_start && (game_mode == boss_pkg::MODE_DUAL));

    assign play_mode = (game_mode == boss_pkg::MODE_SINGLE) ||
                       (game_mode == boss_pkg::MODE_DUAL);

    always_comb begin
        state_nxt = state;
        case (state)
            boss_pkg::FIGHT_IDLE,
            boss_pkg::FIGHT_DEFEATED: begin
                if (start_req) begin
                    state_nxt = boss_pkg::FIGHT_ON;
                end
            end
            boss_pkg::FIGHT_ON: begin
                // hp is still zero while the load pulse is in flight
                if ((boss_hp == '0) && !hp_load) begin
                    state_nxt = boss_pkg::FIGHT_DEFEATED;
                end
            end
            default: state_nxt = boss_pkg::FIGHT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= boss_pkg::FIGHT_IDLE;
            hp_load <= 1'b0;
        end else begin
            state   <= state_nxt;
            hp_load <= (state != boss_pkg::FIGHT_ON) && start_req;  // one cycle, on entry
        end
    end

    assign fight_en   = (state == boss_pkg::FIGHT_ON) && play_mode;
    assign boss_alive = (state == boss_pkg::FIGHT_ON);

    // a fresh fight loads hp exactly once
    a_load_pulse : assert property (
        @(posedge clk) disable iff (!arst_n)
        hp_load |=> !hp_load
    );

endmodule

`default_nettype wire

// File: src/boss_move.sv
// Boss horizontal movement
`timescale 1ns/1ps
`default_nettype none

`include "boss_params.svh"

module boss_move (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             frame_tick,
    input  logic             fight_en,
    input  boss_pkg::mode_t  game_mode,
    input  boss_pkg::coord_t char_x,
    input  boss_pkg::coord_t player_2_x,
    input  boss_pkg::aggro_t char_aggro,
    input  boss_pkg::aggro_t player_2_aggro,
    output boss_pkg::coord_t boss_x
);

    localparam boss_pkg::coord_t X_MAX  = boss_pkg::coord_t'(`SCREEN_W - `BOSS_LNG);
    localparam boss_pkg::coord_t X_INIT = boss_pkg::coord_t'(`BOSS_X_INIT);
    localparam boss_pkg::coord_t STEP   = boss_pkg::coord_t'(`BOSS_STEP);
    localparam boss_pkg::coord_t HALF   = boss_pkg::coord_t'(`BOSS_LNG / 2);

    logic             use_p2;
    boss_pkg::coord_t target;
    logic [12:0]      centre;    // one spare bit so sums cannot wrap
    logic [12:0]      target_w;
    logic             go_right;
    logic             go_left;
    boss_pkg::coord_t boss_x_nxt;

    // ties stay on char
    assign use_p2 = (game_mode == boss_pkg::MODE_DUAL) && (player_2_aggro > char_aggro);
    assign target = use_p2 ? player_2_x : char_x;

    assign centre   = {1'b0, boss_x} + {1'b0, HALF};
    assign target_w = {1'b0, target};

    // dead band of one step around the target
    assign go_right = target_w > (centre + {1'b0, STEP});
    assign go_left  = (target_w + {1'b0, STEP}) < centre;

    always_comb begin
        boss_x_nxt = boss_x;
        if (go_right) begin
            if (boss_x > (X_MAX - STEP)) begin
                boss_x_nxt = X_MAX;     // right screen edge
            end else begin
                boss_x_nxt = boss_x + STEP;
            end
        end else if (go_left) begin
            if (boss_x < STEP) begin
                boss_x_nxt = '0;
            end else begin
                boss_x_nxt = boss_x - STEP;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            boss_x <= X_INIT;
        end else if (frame_tick && fight_en) begin
            boss_x <= boss_x_nxt;
        end
    end

    // body never leaves the screen
    a_on_screen : assert property (
        @(posedge clk) disable iff (!arst_n)
        ({1'b0, boss_x} + 13'(`BOSS_LNG)) <= 13'(`SCREEN_W)
    );

endmodule

`default_nettype wire

// File: src/boss_hp.sv
// Boss hit points and hp bar stage
`timescale 1ns/1ps
`default_nettype none

`include "boss_params.svh"

module boss_hp (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            hp_load,
    input  logic            fight_en,
    input  boss_pkg::mode_t game_mode,
    input  logic            projectile_hit,
    input  logic            melee_hit,
    input  logic            player_2_data_valid,
    input  boss_pkg::hp_t   boss_out_hp,
    input  boss_pkg::vga_t  vga_in,
    output boss_pkg::hp_t   boss_hp,
    output boss_pkg::vga_t  vga_out
);

    localparam boss_pkg::hp_t HP_MAX = boss_pkg::hp_t'(`BOSS_MAX_HP);

    localparam logic [10:0] BAR_X0 = 11'(`HP_BAR_X);
    localparam logic [10:0] BAR_Y0 = 11'(`HP_BAR_Y);
    localparam logic [10:0] BAR_Y1 = 11'(`HP_BAR_Y + `HP_BAR_H);

    boss_pkg::hp_t  dmg;
    boss_pkg::hp_t  remote_hp;
    boss_pkg::hp_t  hp_nxt;
    logic           remote_sync;
    logic [10:0]    bar_len;
    logic           in_bar;
    boss_pkg::vga_t vga_nxt;

    // both hits in one cycle add up
    assign dmg = (projectile_hit ? boss_pkg::hp_t'(`DMG_PROJECTILE) : '0) +
                 (melee_hit      ? boss_pkg::hp_t'(`DMG_MELEE)      : '0);

    assign remote_sync = (game_mode == boss_pkg::MODE_DUAL) && player_2_data_valid;
    assign remote_hp   = (boss_out_hp > HP_MAX) ? HP_MAX : boss_out_hp;  // guard bad link data

    // load, then remote, then local hits
    always_comb begin
        hp_nxt = boss_hp;
        if (hp_load) begin
            hp_nxt = HP_MAX;
        end else if (remote_sync) begin
            hp_nxt = remote_hp;
        end else if (fight_en && (projectile_hit || melee_hit)) begin
            hp_nxt = (boss_hp > dmg) ? boss_hp - dmg : '0;   // saturate at zero
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            boss_hp <= '0;
        end else begin
            boss_hp <= hp_nxt;
        end
    end

    // bar length in pixels
    assign bar_len = {2'b00, boss_hp, 2'b00};

    assign in_bar = (vga_in.vcount >= BAR_Y0) && (vga_in.vcount < BAR_Y1) &&
                    (vga_in.hcount >= BAR_X0) &&
                    ((vga_in.hcount - BAR_X0) < bar_len);

    always_comb begin
        vga_nxt = vga_in;
        if (in_bar) begin
            vga_nxt.rgb = `COLOR_BAR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

    a_hp_max : assert property (
        @(posedge clk) disable iff (!arst_n)
        boss_hp <= HP_MAX
    );

endmodule

`default_nettype wire

// File: src/boss_render.sv
// Boss rectangle render stage
`timescale 1ns/1ps
`default_nettype none

`include "boss_params.svh"

module boss_render (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             boss_alive,
    input  boss_pkg::coord_t boss_x,
    input  boss_pkg::hp_t    boss_hp,
    input  boss_pkg::vga_t   vga_in,
    output boss_pkg::vga_t   vga_out
);

    localparam boss_pkg::coord_t Y_TOP = boss_pkg::coord_t'(`BOSS_Y);
    localparam boss_pkg::coord_t Y_BOT = boss_pkg::coord_t'(`BOSS_Y + `BOSS_HGT);
    localparam boss_pkg::coord_t LNG   = boss_pkg::coord_t'(`BOSS_LNG);

    localparam boss_pkg::hp_t HP_MID = boss_pkg::hp_t'(`HP_MID);
    localparam boss_pkg::hp_t HP_LOW = boss_pkg::hp_t'(`HP_LOW);

    boss_pkg::coord_t px;
    boss_pkg::coord_t py;
    logic             in_rect;
    logic             visible;
    boss_pkg::rgb_t   body_rgb;
    boss_pkg::vga_t   vga_nxt;

    // pixel position of the incoming struct
    assign px = {1'b0, vga_in.hcount};
    assign py = {1'b0, vga_in.vcount};

    assign in_rect = (px >= boss_x) && (px < (boss_x + LNG)) &&
                     (py >= Y_TOP)  && (py < Y_BOT);

    assign visible = !vga_in.hblnk && !vga_in.vblnk;

    // colour fades as hp drops
    always_comb begin
        if (boss_hp > HP_MID) begin
            body_rgb = `COLOR_HIGH;
        end else if (boss_hp > HP_LOW) begin
            body_rgb = `COLOR_MID;
        end else begin
            body_rgb = `COLOR_LOW;
        end
    end

    always_comb begin
        vga_nxt = vga_in;
        if (boss_alive && visible && in_rect) begin
            vga_nxt.rgb = body_rgb;   // boss sits over the bar layer
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/boss_top.sv
// Boss subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "boss_params.svh"

module boss_top (
    input  logic             clk,
    input  logic             arst_n,
    input  boss_pkg::mode_t  game_mode,
    input  logic             game_start,
    input  logic             player2_game_start,
    input  boss_pkg::coord_t char_x,
    input  boss_pkg::coord_t player_2_x,
    input  logic             frame_tick,
    input  logic             projectile_hit,
    input  logic             melee_hit,
    input  logic             player_2_data_valid,
    input  boss_pkg::hp_t    boss_out_hp,
    input  boss_pkg::aggro_t char_aggro,
    input  boss_pkg::aggro_t player_2_aggro,
    input  boss_pkg::vga_t   vga_in,
    output boss_pkg::vga_t   vga_out,
    output boss_pkg::coord_t boss_x,
    output boss_pkg::coord_t boss_y,
    output boss_pkg::hp_t    boss_hp,
    output logic             boss_alive
);

    logic           hp_load;
    logic           fight_en;
    boss_pkg::vga_t vga_mid;   // after the hp bar stage

    assign boss_y = boss_pkg::coord_t'(`BOSS_Y);   // no vertical motion

    boss_ctrl u_ctrl (
        .clk                (clk),
        .arst_n             (arst_n),
        .game_mode          (game_mode),
        .game_start         (game_start),
        .player2_game_start (player2_game_start),
        .boss_hp            (boss_hp),
        .hp_load            (hp_load),
        .fight_en           (fight_en),
        .boss_alive         (boss_alive)
    );

    boss_move u_move (
        .clk            (clk),
        .arst_n         (arst_n),
        .frame_tick     (frame_tick),
        .fight_en       (fight_en),
        .game_mode      (game_mode),
        .char_x         (char_x),
        .player_2_x     (player_2_x),
        .char_aggro     (char_aggro),
        .player_2_aggro (player_2_aggro),
        .boss_x         (boss_x)
    );

    boss_hp u_hp (
        .clk                 (clk),
        .arst_n              (arst_n),
        .hp_load             (hp_load),
        .fight_en            (fight_en),
        .game_mode           (game_mode),
        .projectile_hit      (projectile_hit),
        .melee_hit           (melee_hit),
        .player_2_data_valid (player_2_data_valid),
        .boss_out_hp         (boss_out_hp),
        .vga_in              (vga_in),
        .boss_hp             (boss_hp),
        .vga_out             (vga_mid)
    );

    boss_render u_render (
        .clk        (clk),
        .arst_n     (arst_n),
        .boss_alive (boss_alive),
        .boss_x     (boss_x),
        .boss_hp    (boss_hp),
        .vga_in     (vga_mid),
        .vga_out    (vga_out)
    );

endmodule

`default_nettype wire

// File: verif/boss_top_tb.sv
// Boss subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "boss_params.svh"

module boss_top_tb;

    localparam int TIMEOUT_CYCLES = 20;

    logic             clk;
    logic             arst_n;
    boss_pkg::mode_t  game_mode;
    logic             game_start;
    logic             player2_game_start;
    boss_pkg::coord_t char_x;
    boss_pkg::coord_t player_2_x;
    logic             frame_tick;
    logic             projectile_hit;
    logic             melee_hit;
    logic             player_2_data_valid;
    boss_pkg::hp_t    boss_out_hp;
    boss_pkg::aggro_t char_aggro;
    boss_pkg::aggro_t player_2_aggro;
    boss_pkg::vga_t   vga_in;
    boss_pkg::vga_t   vga_out;
    boss_pkg::coord_t boss_x;
    boss_pkg::coord_t boss_y;
    boss_pkg::hp_t    boss_hp;
    logic             boss_alive;

    integer           seed;
    integer           fd;
    integer           scan_cnt;
    integer           case_cnt;
    integer           fail_cnt;
    integer           err_cnt;
    logic             timed_out;
    reg [8*160-1:0]   text_line;
    reg [8*8-1:0]     op;
    logic [31:0]      f_mode;
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [31:0]      f_c;
    logic [31:0]      f_d;
    logic [31:0]      f_n;
    logic [31:0]      f_e1;
    logic [31:0]      f_e2;

    boss_top UUT (
        .clk                 (clk),
        .arst_n              (arst_n),
        .game_mode           (game_mode),
        .game_start          (game_start),
        .player2_game_start  (player2_game_start),
        .char_x              (char_x),
        .player_2_x          (player_2_x),
        .frame_tick          (frame_tick),
        .projectile_hit      (projectile_hit),
        .melee_hit           (melee_hit),
        .player_2_data_valid (player_2_data_valid),
        .boss_out_hp         (boss_out_hp),
        .char_aggro          (char_aggro),
        .player_2_aggro      (player_2_aggro),
        .vga_in              (vga_in),
        .vga_out             (vga_out),
        .boss_x              (boss_x),
        .boss_y              (boss_y),
        .boss_hp             (boss_hp),
        .boss_alive          (boss_alive)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            err_cnt = err_cnt + 1;
        end
    endtask

    // fight entry and one more cycle for the hp load
    task automatic start_fight();
        integer n;
        n = 0;
        @(posedge clk);
        game_mode          <= f_mode[1:0];
        game_start         <= !f_a[0];
        player2_game_start <= f_a[0];
        @(posedge clk);
        game_start         <= 1'b0;
        player2_game_start <= 1'b0;
        @(negedge clk);
        while ((boss_alive !== 1'b1) && (n < TIMEOUT_CYCLES)) begin
            @(negedge clk);
            n = n + 1;
        end
        if (boss_alive !== 1'b1) begin
            $display("timeout: the boss never came alive after a start request");
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
            check_value("boss_hp", f_e1, boss_hp);
            check_value("boss_alive", f_e2, boss_alive);
        end
    endtask

    task automatic apply_hits();
        integer i;
        for (i = 0; i < f_n; i = i + 1) begin
            @(posedge clk);
            game_mode      <= f_mode[1:0];
            projectile_hit <= f_a[0];
            melee_hit      <= f_b[0];
        end
        @(posedge clk);
        projectile_hit <= 1'b0;
        melee_hit      <= 1'b0;
        @(negedge clk);
        check_value("boss_hp", f_e1, boss_hp);
        @(negedge clk);                         // defeat shows one cycle later
        check_value("boss_alive", f_e2, boss_alive);
    endtask

    // remote hp with local hits in the same cycle
    task automatic sync_remote();
        @(posedge clk);
        game_mode           <= f_mode[1:0];
        player_2_data_valid <= 1'b1;
        boss_out_hp         <= f_a[6:0];
        projectile_hit      <= f_b[0];
        melee_hit           <= f_c[0];
        @(posedge clk);
        player_2_data_valid <= 1'b0;
        projectile_hit      <= 1'b0;
        melee_hit           <= 1'b0;
        @(negedge clk);
        check_value("boss_hp", f_e1, boss_hp);
        @(negedge clk);
        check_value("boss_alive", f_e2, boss_alive);
    endtask

    task automatic tick_frames();
        integer i;
        for (i = 0; i < f_n; i = i + 1) begin
            @(posedge clk);
            game_mode      <= f_mode[1:0];
            char_x         <= f_a[11:0];
            player_2_x     <= f_b[11:0];
            char_aggro     <= f_c[3:0];
            player_2_aggro <= f_d[3:0];
            frame_tick     <= 1'b1;
        end
        @(posedge clk);
        frame_tick <= 1'b0;
        @(negedge clk);
        check_value("boss_x", f_e1, boss_x);
        check_value("boss_y", `BOSS_Y, boss_y);
    endtask

    // one pixel through both video stages in two cycles
    task automatic send_pixel();
        boss_pkg::vga_t pix;
        boss_pkg::rgb_t want;
        pix.hcount = f_a[10:0];
        pix.vcount = f_b[10:0];
        pix.hblnk  = f_c[0];
        pix.vblnk  = f_c[1];
        pix.hsync  = $random(seed);
        pix.vsync  = $random(seed);
        pix.rgb    = $random(seed);             // background colour
        want = f_d[0] ? f_e1[11:0] : pix.rgb;
        @(posedge clk);
        vga_in <= pix;
        @(posedge clk);
        vga_in <= '0;
        @(posedge clk);
        @(negedge clk);
        check_value("vga_out.rgb", want, vga_out.rgb);
        check_value("vga_out.hcount", pix.hcount, vga_out.hcount);
        check_value("vga_out.vcount", pix.vcount, vga_out.vcount);
        check_value("vga_out.sync_blank", {pix.vsync, pix.vblnk, pix.hsync, pix.hblnk},
                    {vga_out.vsync, vga_out.vblnk, vga_out.hsync, vga_out.hblnk});
    endtask

    task automatic run_case();
        integer errs_before;
        errs_before = err_cnt;
        case_cnt = case_cnt + 1;
        if (op == "START") begin
            start_fight();
        end else if (op == "HIT") begin
            apply_hits();
        end else if (op == "REMOTE") begin
            sync_remote();
        end else if (op == "FRAME") begin
            tick_frames();
        end else if (op == "PIXEL") begin
            send_pixel();
        end else begin
            $display("the case file holds an unknown opcode on case %0d", case_cnt);
            err_cnt = err_cnt + 1;
        end
        if ((err_cnt != errs_before) || timed_out) begin
            fail_cnt = fail_cnt + 1;
            $display("case %0d %0s failed", case_cnt, op);
        end else begin
            $display("case %0d %0s ok", case_cnt, op);
        end
    endtask

    initial begin
        seed                = 91;
        case_cnt            = 0;
        fail_cnt            = 0;
        err_cnt             = 0;
        timed_out           = 1'b0;
        arst_n              = 1'b0;
        game_mode           = '0;
        game_start          = 1'b0;
        player2_game_start  = 1'b0;
        char_x              = '0;
        player_2_x          = '0;
        frame_tick          = 1'b0;
        projectile_hit      = 1'b0;
        melee_hit           = 1'b0;
        player_2_data_valid = 1'b0;
        boss_out_hp         = '0;
        char_aggro          = '0;
        player_2_aggro      = '0;
        vga_in              = '0;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("boss_alive", 0, boss_alive);
        check_value("boss_hp", 0, boss_hp);
        check_value("boss_x", `BOSS_X_INIT, boss_x);
        check_value("vga_out", 0, vga_out);
        $display("case 0 RESET %0s", (err_cnt == 0) ? "ok" : "failed");
        if (err_cnt != 0) begin
            fail_cnt = fail_cnt + 1;
        end

        fd = $fopen("verif/boss_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file verif/boss_cases.txt");
            err_cnt = err_cnt + 1;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                text_line = '0;
                if ($fgets(text_line, fd) != 0) begin
                    scan_cnt = $sscanf(text_line, "%s %h %h %h %h %h %h %h %h", op,
                                       f_mode, f_a, f_b, f_c, f_d, f_n, f_e1, f_e2);
                    if (scan_cnt == 9) begin        // comments and blank lines skip
                        run_case();
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d cases run, %0d failed, %0d errors", case_cnt + 1, fail_cnt, err_cnt);
        if ((err_cnt == 0) && (fail_cnt == 0) && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: boss_top.f
+incdir+src
src/boss_pkg.sv
src/boss_ctrl.sv
src/boss_move.sv
src/boss_hp.sv
src/boss_render.sv
src/boss_top.sv
verif/boss_top_tb.sv

// File: verif/boss_cases.txt
# columns op mode a b c d n exp1 exp2, hex; START a=p2 start, HIT a=proj b=melee n=cycles
# REMOTE a=hp b=proj c=melee; FRAME a,b=x c,d=aggro n=ticks; PIXEL a=h b=v c=blank d=chk
PIXEL  0 1F4 1C2 0 0 0  0   0
FRAME  1 064 3E8 2 9 3  1D0 0
START  1 0   0   0 0 0  64  1
PIXEL  1 1F4 1C2 0 1 0  0E2 0
PIXEL  1 2C7 02D 0 1 0  D22 0
PIXEL  1 2C8 02D 0 0 0  0   0
PIXEL  1 1F4 1C2 1 0 0  0   0
HIT    1 1   0   0 0 1  63  1
HIT    1 0   1   0 0 1  60  1
HIT    1 1   1   0 0 1  5C  1
HIT    0 1   1   0 0 1  5C  1
HIT    1 0   1   0 0 B  3B  1
PIXEL  1 1F4 1C2 0 1 0  FA0 0
PIXEL  1 223 02D 0 1 0  D22 0
PIXEL  1 224 02D 0 0 0  0   0
FRAME  1 064 3E8 2 9 4  1C8 0
FRAME  2 064 3E8 2 9 5  1D2 0
FRAME  2 064 3E8 5 5 3  1CC 0
FRAME  1 1FF 3E8 5 5 3  1CE 0
FRAME  1 3FF 000 0 0 F0 3A0 0
FRAME  1 000 3FF 0 0 1D8 000 0
FRAME  0 3FF 000 0 0 4  000 0
PIXEL  1 010 190 0 1 0  FA0 0
PIXEL  1 010 18F 0 0 0  0   0
PIXEL  1 060 190 0 0 0  0   0
REMOTE 2 50  1   1 0 0  50  1
PIXEL  1 020 1F0 0 1 0  0E2 0
REMOTE 1 10  1   0 0 0  4F  1
REMOTE 2 14  0   1 0 0  14  1
PIXEL  1 020 1F0 0 1 0  E11 0
HIT    2 0   1   0 0 7  00  0
PIXEL  1 020 1F0 0 0 0  0   0
FRAME  2 3FF 3FF 0 0 4  000 0
START  2 1   0   0 0 0  64  1
